// File: src/dino_run_params.svh
// Raster is 1280x480 inside 1600x525 totals; colours are packed 24-bit RGB with red on top
`ifndef DINO_RUN_PARAMS_SVH
`define DINO_RUN_PARAMS_SVH

`define H_ACTIVE      1280
`define H_FRONT       32
`define H_SYNC        192
`define H_BACK        96
`define H_TOTAL       1600

`define V_ACTIVE      480
`define V_FRONT       10
`define V_SYNC        2
`define V_BACK        33
`define V_TOTAL       525

`define SPRITE_SIZE   32
`define GROUP_WIDTH   64

`define GROUND_Y      248
`define PTERO_Y       200

`define CACTUS_START  1200
`define GROUP_START   1600
`define LAVA_START    1800
`define PTERO_START   1400

`define DINO_X0       100
`define DINO_Y0       248

`define GROUND_LINE   280
`define EARTH_Y       300

`define SCORE_X       120
`define SCORE_Y       10
`define N_DIGITS      5

`define REPLAY_X      560
`define REPLAY_Y      200
`define REPLAY_W      160

`define ADDR_DINO_X   0
`define ADDR_DINO_Y   1
`define ADDR_REPLAY   19

`define COLOR_SKY     24'h87CEEB
`define COLOR_LINE    24'h000000
`define COLOR_DIRT    24'h8B4513
`define COLOR_EARTH   24'h64280A
`define COLOR_DINO    24'h535353
`define COLOR_CACTUS  24'h228B22
`define COLOR_GROUP   24'h2E8B57
`define COLOR_LAVA    24'hFF4500
`define COLOR_PTERO   24'h8A2BE2
`define COLOR_DIGIT   24'h000000
`define COLOR_BANNER  24'hFFD700

`endif

// File: src/dino_run_pkg.sv
// Widths cover the 1600x525 counters; obstacle x above 2047 wraps inside hpos_t
`default_nettype none

package dino_run_pkg;

    typedef logic [10:0] hpos_t;      // Pixel column and object x
    typedef logic [9:0]  vpos_t;      // Pixel row and object y
    typedef logic [7:0]  color_t;     // One VGA channel
    typedef logic [3:0]  bcd_digit_t;
    typedef logic [5:0]  lfsr_t;

    // Two-state game flow
    typedef enum logic {
        GAME_RUNNING,
        GAME_OVER
    } game_state_t;

endpackage

`default_nettype wire

// File: src/vga_timing.sv
// Counters start at 0 after reset; sync pulses are active low and vga_sync_n is tied low
`timescale 1ns/1ns
`default_nettype none
`include "dino_run_params.svh"

module vga_timing (
    input  logic                clk,
    input  logic                reset,
    output dino_run_pkg::hpos_t hcount,
    output dino_run_pkg::vpos_t vcount,
    output logic                vga_hs,
    output logic                vga_vs,
    output logic                vga_blank_n,
    output logic                vga_sync_n,
    output logic                vga_clk
);

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = (hcount == dino_run_pkg::hpos_t'(`H_TOTAL - 1));
    assign end_of_frame = (vcount == dino_run_pkg::vpos_t'(`V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Rows advance once per line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vcount <= '0;
        end else if (end_of_line) begin
            if (end_of_frame) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    assign vga_hs = !((hcount >= `H_ACTIVE + `H_FRONT) &&
                      (hcount <  `H_ACTIVE + `H_FRONT + `H_SYNC));
    assign vga_vs = !((vcount >= `V_ACTIVE + `V_FRONT) &&
                      (vcount <  `V_ACTIVE + `V_FRONT + `V_SYNC));
    assign vga_blank_n = (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE);
    assign vga_sync_n  = 1'b0;
    assign vga_clk     = hcount[0];   // Half-rate pixel clock

endmodule

`default_nettype wire

// File: src/game_ctrl.sv
// Decodes only addresses 0, 1 and 19; upper writedata bits are ignored, replay acts as a level
`timescale 1ns/1ns
`default_nettype none
`include "dino_run_params.svh"

module game_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                chipselect,
    input  logic                write,
    input  logic [8:0]          address,
    input  logic [31:0]         writedata,
    input  dino_run_pkg::hpos_t cactus_x,
    input  dino_run_pkg::hpos_t group_x,
    input  dino_run_pkg::hpos_t lava_x,
    input  dino_run_pkg::hpos_t ptero_x,
    output dino_run_pkg::hpos_t dino_x,
    output dino_run_pkg::vpos_t dino_y,
    output logic                running,
    output logic                restart
);

    dino_run_pkg::game_state_t state;
    logic                      replay;
    logic                      bus_we;
    logic                      hit;

    // Dino box is always 32x32, obstacle boxes are 32 high
    function automatic logic overlap(input int ax, input int ay, input int bx,
                                     input int by, input int bw);
        return (ax < bx + bw) && (ax + `SPRITE_SIZE > bx) &&
               (ay < by + `SPRITE_SIZE) && (ay + `SPRITE_SIZE > by);
    endfunction

    assign bus_we = chipselect && write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            dino_x <= dino_run_pkg::hpos_t'(`DINO_X0);
            dino_y <= dino_run_pkg::vpos_t'(`DINO_Y0);
            replay <= 1'b0;
        end else if (bus_we) begin
            case (address)
                9'(`ADDR_DINO_X): dino_x <= writedata[10:0];
                9'(`ADDR_DINO_Y): dino_y <= writedata[9:0];
                9'(`ADDR_REPLAY): replay <= writedata[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        hit = overlap(int'(dino_x), int'(dino_y), int'(cactus_x), `GROUND_Y, `SPRITE_SIZE) ||
              overlap(int'(dino_x), int'(dino_y), int'(group_x), `GROUND_Y, `GROUP_WIDTH) ||
              overlap(int'(dino_x), int'(dino_y), int'(lava_x), `GROUND_Y, `SPRITE_SIZE) ||
              overlap(int'(dino_x), int'(dino_y), int'(ptero_x), `PTERO_Y, `SPRITE_SIZE);
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= dino_run_pkg::GAME_RUNNING;
        end else begin
            case (state)
                dino_run_pkg::GAME_RUNNING: begin
                    if (hit) state <= dino_run_pkg::GAME_OVER;
                end
                dino_run_pkg::GAME_OVER: begin
                    if (replay) state <= dino_run_pkg::GAME_RUNNING;
                end
                default: state <= dino_run_pkg::GAME_RUNNING;
            endcase
        end
    end

    assign running = (state == dino_run_pkg::GAME_RUNNING);
    assign restart = (state == dino_run_pkg::GAME_OVER) && replay;  // Drops as state leaves OVER

endmodule

`default_nettype wire

// File: src/obstacle_field.sv
// Speed is fixed at one pixel per tick; wrap targets past 2047 alias back onto the screen
`timescale 1ns/1ns
`default_nettype none
`include "dino_run_params.svh"

module obstacle_field #(
    parameter int MOTION_PERIOD = 2000000
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                running,
    input  logic                restart,
    output logic                motion_tick,
    output dino_run_pkg::hpos_t cactus_x,
    output dino_run_pkg::hpos_t group_x,
    output dino_run_pkg::hpos_t lava_x,
    output dino_run_pkg::hpos_t ptero_x
);

    localparam int TIMER_W = (MOTION_PERIOD > 0) ? $clog2(MOTION_PERIOD + 1) : 1;

    logic [TIMER_W-1:0]  timer;
    dino_run_pkg::lfsr_t lfsr;

    // One pixel left, or back past the right edge once at the left border
    function automatic dino_run_pkg::hpos_t step(input dino_run_pkg::hpos_t x,
                                                 input dino_run_pkg::hpos_t offset);
        if (x <= 1) begin
            return dino_run_pkg::hpos_t'(`H_ACTIVE) + offset;
        end
        return x - 1'b1;
    endfunction

    assign motion_tick = running && (timer == TIMER_W'(MOTION_PERIOD));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            timer <= '0;
        end else if (restart) begin
            timer <= '0;
        end else if (running) begin
            timer <= motion_tick ? '0 : timer + 1'b1;
        end
    end

    // x^6 + x^5 + 1, advanced once per tick
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            lfsr <= 6'b101011;
        end else if (motion_tick) begin
            lfsr <= {lfsr[4:0], lfsr[5] ^ lfsr[4]};
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cactus_x <= dino_run_pkg::hpos_t'(`CACTUS_START);
            group_x  <= dino_run_pkg::hpos_t'(`GROUP_START);
            lava_x   <= dino_run_pkg::hpos_t'(`LAVA_START);
            ptero_x  <= dino_run_pkg::hpos_t'(`PTERO_START);
        end else if (restart) begin
            cactus_x <= dino_run_pkg::hpos_t'(`CACTUS_START);
            group_x  <= dino_run_pkg::hpos_t'(`GROUP_START);
            lava_x   <= dino_run_pkg::hpos_t'(`LAVA_START);
            ptero_x  <= dino_run_pkg::hpos_t'(`PTERO_START);
        end else if (motion_tick) begin
            cactus_x <= step(cactus_x, dino_run_pkg::hpos_t'({lfsr, 4'b0}));
            group_x  <= step(group_x, dino_run_pkg::hpos_t'({~lfsr, 4'b0}));
            lava_x   <= step(lava_x, dino_run_pkg::hpos_t'({lfsr[3:0], 6'b0}));
            ptero_x  <= step(ptero_x, dino_run_pkg::hpos_t'({lfsr[5:2], 6'b0}));
        end
    end

endmodule

`default_nettype wire

// File: src/score_bcd.sv
// Counts motion ticks only; restart wins over a tick on the same edge, 99999 wraps to 0
`timescale 1ns/1ns
`default_nettype none
`include "dino_run_params.svh"

module score_bcd (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     motion_tick,
    input  logic                     restart,
    output dino_run_pkg::bcd_digit_t digits [`N_DIGITS]
);

    logic [`N_DIGITS-1:0] carry;   // carry[i] set when digit i must step

    always_comb begin
        carry[0] = 1'b1;
        for (int i = 1; i < `N_DIGITS; i++) begin
            carry[i] = carry[i-1] && (digits[i-1] == 4'd9);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `N_DIGITS; i++) begin
                digits[i] <= '0;
            end
        end else if (restart) begin
            for (int i = 0; i < `N_DIGITS; i++) begin
                digits[i] <= '0;
            end
        end else if (motion_tick) begin
            for (int i = 0; i < `N_DIGITS; i++) begin
                if (carry[i]) begin
                    digits[i] <= (digits[i] == 4'd9) ? 4'd0 : digits[i] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pixel_renderer.sv
// RGB is registered one clock behind hcount/vcount; objects are plain boxes, digits 0..9 only
`timescale 1ns/1ns
`default_nettype none
`include "dino_run_params.svh"

module pixel_renderer (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     running,
    input  dino_run_pkg::hpos_t      hcount,
    input  dino_run_pkg::vpos_t      vcount,
    input  dino_run_pkg::hpos_t      dino_x,
    input  dino_run_pkg::vpos_t      dino_y,
    input  dino_run_pkg::hpos_t      cactus_x,
    input  dino_run_pkg::hpos_t      group_x,
    input  dino_run_pkg::hpos_t      lava_x,
    input  dino_run_pkg::hpos_t      ptero_x,
    input  dino_run_pkg::bcd_digit_t digits [`N_DIGITS],
    output dino_run_pkg::color_t     vga_r,
    output dino_run_pkg::color_t     vga_g,
    output dino_run_pkg::color_t     vga_b
);

    // Glyph rows top to bottom, bit 7 is the left column
    localparam logic [7:0] FONT [10][8] = '{
        '{8'h38, 8'h44, 8'h4C, 8'h54, 8'h64, 8'h44, 8'h38, 8'h00},
        '{8'h10, 8'h30, 8'h10, 8'h10, 8'h10, 8'h10, 8'h38, 8'h00},
        '{8'h38, 8'h44, 8'h04, 8'h08, 8'h10, 8'h20, 8'h7C, 8'h00},
        '{8'h7C, 8'h08, 8'h10, 8'h08, 8'h04, 8'h44, 8'h38, 8'h00},
        '{8'h08, 8'h18, 8'h28, 8'h48, 8'h7C, 8'h08, 8'h08, 8'h00},
        '{8'h7C, 8'h40, 8'h78, 8'h04, 8'h04, 8'h44, 8'h38, 8'h00},
        '{8'h18, 8'h20, 8'h40, 8'h78, 8'h44, 8'h44, 8'h38, 8'h00},
        '{8'h7C, 8'h04, 8'h08, 8'h10, 8'h20, 8'h20, 8'h20, 8'h00},
        '{8'h38, 8'h44, 8'h44, 8'h38, 8'h44, 8'h44, 8'h38, 8'h00},
        '{8'h38, 8'h44, 8'h44, 8'h3C, 8'h04, 8'h08, 8'h30, 8'h00}
    };

    dino_run_pkg::hpos_t      score_dx;
    dino_run_pkg::vpos_t      score_dy;
    logic                     in_score;
    dino_run_pkg::bcd_digit_t glyph_digit;
    logic                     glyph_bit;
    logic                     active;
    logic [23:0]              color_next;

    function automatic logic in_box(input int px, input int py, input int bx,
                                    input int by, input int w, input int h);
        return (px >= bx) && (px < bx + w) && (py >= by) && (py < by + h);
    endfunction

    assign score_dx = hcount - dino_run_pkg::hpos_t'(`SCORE_X);
    assign score_dy = vcount - dino_run_pkg::vpos_t'(`SCORE_Y);
    assign in_score = in_box(int'(hcount), int'(vcount), `SCORE_X, `SCORE_Y,
                             8 * `N_DIGITS, 8);
    assign active   = (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE);

    // Leftmost glyph is the most significant digit
    always_comb begin
        glyph_digit = '0;
        for (int i = 0; i < `N_DIGITS; i++) begin
            if (score_dx[5:3] == 3'(`N_DIGITS - 1 - i)) glyph_digit = digits[i];
        end
        glyph_bit = FONT[glyph_digit][score_dy[2:0]][3'd7 - score_dx[2:0]];
    end

    always_comb begin
        if (!active) begin
            color_next = '0;
        end else if (running) begin
            if (vcount < `GROUND_LINE) color_next = `COLOR_SKY;
            else if (vcount == `GROUND_LINE) color_next = `COLOR_LINE;
            else if (vcount <= `EARTH_Y) color_next = `COLOR_DIRT;
            else color_next = `COLOR_EARTH;

            if (in_box(int'(hcount), int'(vcount), int'(dino_x), int'(dino_y),
                       `SPRITE_SIZE, `SPRITE_SIZE)) color_next = `COLOR_DINO;
            if (in_box(int'(hcount), int'(vcount), int'(cactus_x), `GROUND_Y,
                       `SPRITE_SIZE, `SPRITE_SIZE)) color_next = `COLOR_CACTUS;
            if (in_box(int'(hcount), int'(vcount), int'(group_x), `GROUND_Y,
                       `GROUP_WIDTH, `SPRITE_SIZE)) color_next = `COLOR_GROUP;
            if (in_box(int'(hcount), int'(vcount), int'(lava_x), `GROUND_Y,
                       `SPRITE_SIZE, `SPRITE_SIZE)) color_next = `COLOR_LAVA;
            if (in_box(int'(hcount), int'(vcount), int'(ptero_x), `PTERO_Y,
                       `SPRITE_SIZE, `SPRITE_SIZE)) color_next = `COLOR_PTERO;

            if (in_score && glyph_bit) color_next = `COLOR_DIGIT;   // Clear bits show through
        end else begin
            color_next = `COLOR_SKY;
            if (in_box(int'(hcount), int'(vcount), `REPLAY_X, `REPLAY_Y,
                       `REPLAY_W, `SPRITE_SIZE)) color_next = `COLOR_BANNER;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vga_r <= '0;
            vga_g <= '0;
            vga_b <= '0;
        end else begin
            vga_r <= color_next[23:16];
            vga_g <= color_next[15:8];
            vga_b <= color_next[7:0];
        end
    end

endmodule

`default_nettype wire

// File: src/dino_run_top.sv
// One motion tick per MOTION_PERIOD+1 clocks; the bus has no wait states and no read path
`timescale 1ns/1ns
`default_nettype none
`include "dino_run_params.svh"

module dino_run_top #(
    parameter int MOTION_PERIOD = 2000000
) (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 chipselect,
    input  logic                 write,
    input  logic [8:0]           address,
    input  logic [31:0]          writedata,
    output dino_run_pkg::color_t vga_r,
    output dino_run_pkg::color_t vga_g,
    output dino_run_pkg::color_t vga_b,
    output logic                 vga_hs,
    output logic                 vga_vs,
    output logic                 vga_blank_n,
    output logic                 vga_sync_n,
    output logic                 vga_clk
);

    dino_run_pkg::hpos_t      hcount;
    dino_run_pkg::vpos_t      vcount;
    dino_run_pkg::hpos_t      dino_x;
    dino_run_pkg::vpos_t      dino_y;
    dino_run_pkg::hpos_t      cactus_x;
    dino_run_pkg::hpos_t      group_x;
    dino_run_pkg::hpos_t      lava_x;
    dino_run_pkg::hpos_t      ptero_x;
    dino_run_pkg::bcd_digit_t digits [`N_DIGITS];
    logic                     running;
    logic                     restart;
    logic                     motion_tick;

    vga_timing u_timing (
        .clk, .reset, .hcount, .vcount,
        .vga_hs, .vga_vs, .vga_blank_n, .vga_sync_n, .vga_clk
    );

    game_ctrl u_ctrl (
        .clk, .reset, .chipselect, .write, .address, .writedata,
        .cactus_x, .group_x, .lava_x, .ptero_x,
        .dino_x, .dino_y, .running, .restart
    );

    obstacle_field #(.MOTION_PERIOD(MOTION_PERIOD)) u_field (
        .clk, .reset, .running, .restart, .motion_tick,
        .cactus_x, .group_x, .lava_x, .ptero_x
    );

    score_bcd u_score (
        .clk, .reset, .motion_tick, .restart, .digits
    );

    pixel_renderer u_render (
        .clk, .reset, .running, .hcount, .vcount, .dino_x, .dino_y,
        .cactus_x, .group_x, .lava_x, .ptero_x, .digits,
        .vga_r, .vga_g, .vga_b
    );

endmodule

`default_nettype wire

// File: verification/dino_run_assertions.sv
// Bound into dino_run_top to see vga_timing and game_ctrl outputs; idle while reset is high
`timescale 1ns/1ns
`default_nettype none
`include "dino_run_params.svh"

module dino_run_assertions (
    input logic                clk,
    input logic                reset,
    input dino_run_pkg::hpos_t hcount,
    input dino_run_pkg::vpos_t vcount,
    input logic                vga_hs,
    input logic                vga_blank_n,
    input logic                running,
    input logic                restart
);

    hs_in_window: assert property (@(posedge clk) disable iff (reset)
        !vga_hs |-> (hcount >= `H_ACTIVE + `H_FRONT) &&
                    (hcount < `H_ACTIVE + `H_FRONT + `H_SYNC))
        else $error("vga_hs low outside the sync window");

    blank_in_active: assert property (@(posedge clk) disable iff (reset)
        vga_blank_n |-> (hcount < `H_ACTIVE) && (vcount < `V_ACTIVE))
        else $error("vga_blank_n high outside the active area");

    // Game over holds until replay
    over_holds: assert property (@(posedge clk) disable iff (reset)
        !running && !restart |=> !running)
        else $error("game left the over state without a restart");

endmodule

bind dino_run_top dino_run_assertions u_assertions (
    .clk(clk), .reset(reset), .hcount(hcount), .vcount(vcount),
    .vga_hs(vga_hs), .vga_blank_n(vga_blank_n), .running(running), .restart(restart)
);

`default_nettype wire

// File: verification/dino_run_tb.sv
// Runs the core with a 100-cycle motion tick; pixel coordinates come from counting clocks
`timescale 1ns/1ns
`default_nettype none
`include "dino_run_params.svh"

module dino_run_tb;

    localparam longint FRAME = `H_TOTAL * `V_TOTAL;

    // Glyph rows top to bottom, bit 7 on the left
    localparam logic [7:0] GLYPHS [10][8] = '{
        '{8'h38, 8'h44, 8'h4C, 8'h54, 8'h64, 8'h44, 8'h38, 8'h00},
        '{8'h10, 8'h30, 8'h10, 8'h10, 8'h10, 8'h10, 8'h38, 8'h00},
        '{8'h38, 8'h44, 8'h04, 8'h08, 8'h10, 8'h20, 8'h7C, 8'h00},
        '{8'h7C, 8'h08, 8'h10, 8'h08, 8'h04, 8'h44, 8'h38, 8'h00},
        '{8'h08, 8'h18, 8'h28, 8'h48, 8'h7C, 8'h08, 8'h08, 8'h00},
        '{8'h7C, 8'h40, 8'h78, 8'h04, 8'h04, 8'h44, 8'h38, 8'h00},
        '{8'h18, 8'h20, 8'h40, 8'h78, 8'h44, 8'h44, 8'h38, 8'h00},
        '{8'h7C, 8'h04, 8'h08, 8'h10, 8'h20, 8'h20, 8'h20, 8'h00},
        '{8'h38, 8'h44, 8'h44, 8'h38, 8'h44, 8'h44, 8'h38, 8'h00},
        '{8'h38, 8'h44, 8'h44, 8'h3C, 8'h04, 8'h08, 8'h30, 8'h00}
    };

    logic                 clk;
    logic                 reset;
    logic                 chipselect;
    logic                 write;
    logic [8:0]           address;
    logic [31:0]          writedata;
    dino_run_pkg::color_t vga_r;
    dino_run_pkg::color_t vga_g;
    dino_run_pkg::color_t vga_b;
    logic                 vga_hs;
    logic                 vga_vs;
    logic                 vga_blank_n;
    logic                 vga_sync_n;
    logic                 vga_clk;
    longint               cycles;   // Rising edges since reset release

    dino_run_top #(.MOTION_PERIOD(99)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            cycles <= 0;
        end else begin
            cycles <= cycles + 1;
        end
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("tests failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_color(input string name, input dino_run_pkg::color_t got,
                               input dino_run_pkg::color_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH time=%0t %s got=%h expected=%h",
                                    $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("MISMATCH time=%0t %s got=%b expected=%b",
                                    $time, name, got, exp));
        end
    endtask

    task automatic compare_rgb(input int h, input int v, input dino_run_pkg::color_t r,
                               input dino_run_pkg::color_t g, input dino_run_pkg::color_t b,
                               input logic [23:0] exp);
        check_color($sformatf("vga_r(%0d,%0d)", h, v), r, exp[23:16]);
        check_color($sformatf("vga_g(%0d,%0d)", h, v), g, exp[15:8]);
        check_color($sformatf("vga_b(%0d,%0d)", h, v), b, exp[7:0]);
    endtask

    // Called on a falling edge; write lands on the next rising edge
    task automatic bus_write(input logic [8:0] addr, input logic [31:0] data);
        chipselect = 1'b1;
        write = 1'b1;
        address = addr;
        writedata = data;
        @(negedge clk);
        chipselect = 1'b0;
        write = 1'b0;
    endtask

    // RGB seen after edge n belongs to the counters after edge n-1
    task automatic sample_pixel(input int h, input int v, output dino_run_pkg::color_t r,
                                output dino_run_pkg::color_t g,
                                output dino_run_pkg::color_t b, output longint at);
        int waited;
        waited = 0;
        at = -1;
        while (at < 0) begin
            @(negedge clk);
            waited++;
            if (waited > FRAME + 4) begin
                stop_on_error($sformatf("pixel (%0d,%0d) never came up within a frame", h, v));
            end
            if (cycles >= 1 && (cycles - 1) % FRAME == longint'(v) * `H_TOTAL + h) begin
                at = cycles - 1;
                r = vga_r;
                g = vga_g;
                b = vga_b;
            end
        end
    endtask

    function automatic logic [23:0] digit_color(input int h, input int v, input int score);
        int dx;
        int value;
        dx = h - `SCORE_X;
        value = (score / (10 ** (`N_DIGITS - 1 - dx / 8))) % 10;   // Left slot is top digit
        return GLYPHS[value][v - `SCORE_Y][7 - dx % 8] ? `COLOR_DIGIT : `COLOR_SKY;
    endfunction

    task automatic check_score_area(input bit game_over, input longint base);
        dino_run_pkg::color_t r, g, b;
        longint at;
        int score;
        logic [23:0] expected;
        for (int v = `SCORE_Y; v < `SCORE_Y + 8; v++) begin
            for (int h = `SCORE_X; h < `SCORE_X + 8 * `N_DIGITS; h++) begin
                sample_pixel(h, v, r, g, b, at);
                score = int'(((at - base) / 100) % 100000);   // One tick per 100 clocks
                expected = game_over ? 24'(`COLOR_SKY) : digit_color(h, v, score);
                compare_rgb(h, v, r, g, b, expected);
            end
        end
    endtask

    task automatic test_raster();
        int waited;
        longint h;
        longint v;
        waited = 0;
        while (cycles % `H_TOTAL != 0) begin
            @(negedge clk);
            waited++;
            if (waited > `H_TOTAL) begin
                stop_on_error("no line start seen within one line time");
            end
        end
        for (int i = 0; i < `H_TOTAL; i++) begin
            h = cycles % `H_TOTAL;
            v = (cycles / `H_TOTAL) % `V_TOTAL;
            check_bit("vga_hs", vga_hs, !(h >= `H_ACTIVE + `H_FRONT &&
                                          h < `H_ACTIVE + `H_FRONT + `H_SYNC));
            check_bit("vga_blank_n", vga_blank_n, h < `H_ACTIVE && v < `V_ACTIVE);
            check_bit("vga_sync_n", vga_sync_n, 1'b0);
            check_bit("vga_clk", vga_clk, h[0]);
            @(negedge clk);
        end
    endtask

    // Six lines around the vertical sync pulse
    task automatic test_vsync();
        int waited;
        longint v;
        waited = 0;
        while (cycles % FRAME != longint'(`V_ACTIVE + `V_FRONT - 2) * `H_TOTAL) begin
            @(negedge clk);
            waited++;
            if (waited > FRAME) begin
                stop_on_error("vertical front porch not reached within one frame time");
            end
        end
        for (int i = 0; i < 6 * `H_TOTAL; i++) begin
            v = (cycles / `H_TOTAL) % `V_TOTAL;
            check_bit("vga_vs", vga_vs, !(v >= `V_ACTIVE + `V_FRONT &&
                                          v < `V_ACTIVE + `V_FRONT + `V_SYNC));
            @(negedge clk);
        end
    endtask

    task automatic test_background();
        int rows [4];
        logic [23:0] shades [4];
        dino_run_pkg::color_t r, g, b;
        longint at;
        rows = '{100, `GROUND_LINE, 290, 400};
        shades = '{`COLOR_SKY, `COLOR_LINE, `COLOR_DIRT, `COLOR_EARTH};
        for (int i = 0; i < 4; i++) begin
            sample_pixel(50, rows[i], r, g, b, at);
            if (at >= FRAME) begin
                stop_on_error("background rows were sampled after the first frame");
            end
            compare_rgb(50, rows[i], r, g, b, shades[i]);
        end
    endtask

    task automatic test_dino_move();
        int new_x;
        dino_run_pkg::color_t r, g, b;
        longint at;
        logic [23:0] expected;
        new_x = 400 + int'($urandom % 701);
        bus_write(`ADDR_DINO_X, 32'(new_x));
        sample_pixel(new_x + 16, 20, r, g, b, at);
        compare_rgb(new_x + 16, 20, r, g, b, `COLOR_DINO);
        sample_pixel(`DINO_X0, 260, r, g, b, at);
        expected = `COLOR_SKY;
        if ({r, g, b} == `COLOR_CACTUS || {r, g, b} == `COLOR_GROUP ||
            {r, g, b} == `COLOR_LAVA) begin
            expected = {r, g, b};   // Obstacle passing the old spot
        end
        compare_rgb(`DINO_X0, 260, r, g, b, expected);
    endtask

    task automatic test_game_over();
        int frames;
        bit banner;
        dino_run_pkg::color_t r, g, b;
        longint at;
        bus_write(`ADDR_DINO_X, `DINO_X0);
        bus_write(`ADDR_DINO_Y, `DINO_Y0);
        frames = 0;
        banner = 1'b0;
        while (!banner) begin
            sample_pixel(600, 210, r, g, b, at);
            banner = ({r, g, b} == `COLOR_BANNER);
            frames++;
            if (!banner && frames > 8) begin
                stop_on_error("replay banner did not appear within 8 frames");
            end
        end
        check_score_area(1'b1, 0);
    endtask

    task automatic test_replay();
        longint base;
        dino_run_pkg::color_t r, g, b;
        longint at;
        bus_write(`ADDR_DINO_Y, 0);   // Keep the restarted run collision free
        bus_write(`ADDR_DINO_X, 400);   // Dino clear of the score digits
        bus_write(`ADDR_REPLAY, 1);
        base = cycles + 1;            // Restart clears timer and score on the next edge
        bus_write(`ADDR_REPLAY, 0);
        sample_pixel(50, `GROUND_LINE, r, g, b, at);
        compare_rgb(50, `GROUND_LINE, r, g, b, `COLOR_LINE);
        check_score_area(1'b0, base);
    endtask

    initial begin
        void'($urandom(32'ha9573847));
        reset = 1'b1;
        chipselect = 1'b0;
        write = 1'b0;
        address = '0;
        writedata = '0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        bus_write(`ADDR_DINO_Y, 0);   // Dino out of the ground row
        test_raster();
        test_background();
        test_vsync();
        test_dino_move();
        check_score_area(1'b0, 0);
        test_game_over();
        test_replay();
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/dino_run_pkg.sv
src/vga_timing.sv
src/game_ctrl.sv
src/obstacle_field.sv
src/score_bcd.sv
src/pixel_renderer.sv
src/dino_run_top.sv
verification/dino_run_assertions.sv
verification/dino_run_tb.sv

// File: run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it; the exit status is the simulator's
cd "$(dirname "$0")" &&
    verilator --binary --timing --assert -Wno-fatal --top-module dino_run_tb \
        -f flist.f -o dino_run_sim &&
    ./obj_dir/dino_run_sim ||
    exit 1
